//--- rs.f
+incdir+tb
rtl/rs_pkg.sv
rtl/rs_grant_select.sv
rtl/rs_operand_capture.sv
rtl/rs_entry_table.sv
rtl/rs_top.sv
tb/rs_tb.sv

//--- Makefile
# Verilator build and run for the reservation station testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
TOP       = rs_tb
FILELIST  = rs.f

.PHONY: sim clean

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir

//--- tb/rs_tb_tests.svh
// directed test tasks for the reservation station and their reference arithmetic

////////////////////
// reference
////////////////////

// leading run of valid lanes from lane 0
function automatic int lead_run_len(input logic [2:0] mask);
    int n;
    n = 0;
    while (n < rs_pkg::LANES && mask[n]) begin
        n++;
    end
    return n;
endfunction

function automatic int min_int(input int a, input int b);
    return (a < b) ? a : b;
endfunction

// register-file operands with random payload and dest
task automatic drive_ready_lane(input int k);
    id_valid[k]  = 1'b1;
    src1_used[k] = 1'b1;
    src2_used[k] = 1'b1;
    id_op[k]     = next_rand();
    rs1_value[k] = next_rand();
    rs2_value[k] = next_rand();
    dest_tag[k]  = rs_pkg::rob_tag_t'(next_rand() >> 16);
endtask

// one issue lane against the entry it should carry
task automatic check_lane(input string name, input int k, input int idx,
                          input logic [31:0] op, input logic [31:0] v1,
                          input logic [31:0] v2, input rs_pkg::rob_tag_t dest);
    check_value(name, 1, 32'(issue_valid[k]));
    check_value(name, idx, 32'(issue_idx[k]));
    check_value(name, op, issue_op[k]);
    check_value(name, v1, issue_v1[k]);
    check_value(name, v2, issue_v2[k]);
    check_value(name, 32'(dest), 32'(issue_dest[k]));
endtask

////////////////////
// tests
////////////////////

task automatic reset_state();
    next_cycle();
    issue_en = 1'b1;
    sample_point();
    check_value("reset_state", NUM_RS, 32'(free_count));
    check_value("reset_state", 0, 32'(issue_count));
    check_value("reset_state", 0, 32'(issue_valid));
endtask

task automatic ready_dispatch_issue();
    rs_pkg::op_t [rs_pkg::LANES-1:0]      exp_op;
    rs_pkg::word_t [rs_pkg::LANES-1:0]    exp_v1;
    rs_pkg::word_t [rs_pkg::LANES-1:0]    exp_v2;
    rs_pkg::rob_tag_t [rs_pkg::LANES-1:0] exp_dest;
    next_cycle();
    dispatch_en = 1'b1;
    for (int k = 0; k < rs_pkg::LANES; k++) begin
        drive_ready_lane(k);
    end
    exp_op   = id_op;
    exp_v1   = rs1_value;
    exp_v2   = rs2_value;
    exp_dest = dest_tag;
    sample_point();
    // write only lands at the edge
    check_value("ready_dispatch_issue", NUM_RS, 32'(free_count));
    next_cycle();
    issue_en = 1'b1;
    sample_point();
    check_value("ready_dispatch_issue", NUM_RS - 3, 32'(free_count));
    check_value("ready_dispatch_issue", 3, 32'(issue_count));
    for (int k = 0; k < rs_pkg::LANES; k++) begin
        check_lane("ready_dispatch_issue", k, k, exp_op[k], exp_v1[k], exp_v2[k], exp_dest[k]);
    end
    // three more with issue held off
    next_cycle();
    dispatch_en = 1'b1;
    for (int k = 0; k < rs_pkg::LANES; k++) begin
        drive_ready_lane(k);
    end
    sample_point();
    check_value("ready_dispatch_issue", 0, 32'(issue_count));
    next_cycle();
    sample_point();
    check_value("ready_dispatch_issue", NUM_RS - 6, 32'(free_count));
endtask

task automatic tag_wait_wakeup();
    rs_pkg::rob_tag_t tag_a;
    rs_pkg::rob_tag_t tag_b;
    rs_pkg::rob_tag_t dest_a;
    rs_pkg::rob_tag_t dest_b;
    rs_pkg::op_t      op_a;
    rs_pkg::op_t      op_b;
    rs_pkg::word_t    rf2;
    rs_pkg::word_t    bus_val;
    rs_pkg::word_t    rob_val;
    clear_table();
    // two distinct nonzero tags
    tag_a = rs_pkg::rob_tag_t'(next_rand() % 31 + 1);
    tag_b = rs_pkg::rob_tag_t'(32'(tag_a) % 31 + 1);
    next_cycle();
    dispatch_en = 1'b1;
    drive_ready_lane(0);
    mt_tag1[0] = tag_a;
    op_a       = id_op[0];
    rf2        = rs2_value[0];
    dest_a     = dest_tag[0];
    sample_point();
    // pending src1 keeps the entry back
    for (int c = 0; c < 4; c++) begin
        next_cycle();
        issue_en = 1'b1;
        sample_point();
        check_value("tag_wait_wakeup", 0, 32'(issue_count));
    end
    bus_val = next_rand();
    next_cycle();
    issue_en     = 1'b1;
    complete_en  = 1'b1;
    cdb_tag[1]   = tag_a;
    cdb_value[1] = bus_val;
    sample_point();
    check_value("tag_wait_wakeup", 0, 32'(issue_count));
    next_cycle();
    issue_en = 1'b1;
    sample_point();
    check_value("tag_wait_wakeup", 1, 32'(issue_count));
    check_lane("tag_wait_wakeup", 0, 0, op_a, bus_val, rf2, dest_a);
    // src1 from the rob and src2 caught off the cdb at dispatch
    rob_val = next_rand();
    bus_val = next_rand();
    next_cycle();
    dispatch_en = 1'b1;
    drive_ready_lane(0);
    mt_tag1[0]    = tag_a;
    mt_ready1[0]  = 1'b1;
    rob_value1[0] = rob_val;
    mt_tag2[0]    = tag_b;
    complete_en   = 1'b1;
    cdb_tag[2]    = tag_b;
    cdb_value[2]  = bus_val;
    op_b          = id_op[0];
    dest_b        = dest_tag[0];
    sample_point();
    next_cycle();
    issue_en = 1'b1;
    sample_point();
    // entry 0 still held by execute so the new one sits in 1
    check_value("tag_wait_wakeup", 1, 32'(issue_count));
    check_lane("tag_wait_wakeup", 0, 1, op_b, rob_val, bus_val, dest_b);
endtask

task automatic stall_and_release();
    clear_table();
    next_cycle();
    dispatch_en = 1'b1;
    drive_ready_lane(0);
    drive_ready_lane(1);
    sample_point();
    // stalled pass then accepted pass on the same two entries
    for (int p = 0; p < 2; p++) begin
        next_cycle();
        issue_en = 1'b1;
        ex_stall = (p == 0);
        sample_point();
        check_value("stall_and_release", 2, 32'(issue_count));
        check_value("stall_and_release", 3, 32'(issue_valid));
        check_value("stall_and_release", 0, 32'(issue_idx[0]));
        check_value("stall_and_release", 1, 32'(issue_idx[1]));
    end
    next_cycle();
    issue_en = 1'b1;
    sample_point();
    check_value("stall_and_release", 0, 32'(issue_count));
    check_value("stall_and_release", NUM_RS - 2, 32'(free_count));
    next_cycle();
    release_valid  = 3'b011;
    release_idx[0] = IDX_W'(0);
    release_idx[1] = IDX_W'(1);
    sample_point();
    check_value("stall_and_release", NUM_RS - 2, 32'(free_count));
    next_cycle();
    sample_point();
    check_value("stall_and_release", NUM_RS, 32'(free_count));
endtask

task automatic full_table();
    logic [2:0] mask;
    int         exp_free;
    int         steps;
    clear_table();
    exp_free = NUM_RS;
    steps    = 0;
    while (exp_free != 0) begin
        if (steps == TIMEOUT) begin
            $display("full_table: table still not full after %0d dispatch cycles", TIMEOUT);
            $display("** FAIL **");
            $fatal(1, "full_table timed out");
        end
        next_cycle();
        dispatch_en = 1'b1;
        mask        = 3'(next_rand() >> 16);
        for (int k = 0; k < rs_pkg::LANES; k++) begin
            if (mask[k]) begin
                drive_ready_lane(k);
            end
        end
        sample_point();
        check_value("full_table", exp_free, 32'(free_count));
        exp_free = exp_free - min_int(lead_run_len(mask), exp_free);
        steps++;
    end
    // another dispatch into the full table finds no slot
    next_cycle();
    dispatch_en = 1'b1;
    for (int k = 0; k < rs_pkg::LANES; k++) begin
        drive_ready_lane(k);
    end
    sample_point();
    check_value("full_table", 0, 32'(free_count));
    next_cycle();
    sample_point();
    check_value("full_table", 0, 32'(free_count));
endtask

task automatic flush_all();
    next_cycle();
    issue_en = 1'b1;
    sample_point();
    check_value("flush_all", 3, 32'(issue_count));
    next_cycle();
    flush    = 1'b1;
    issue_en = 1'b1;
    sample_point();
    next_cycle();
    issue_en = 1'b1;
    sample_point();
    check_value("flush_all", NUM_RS, 32'(free_count));
    check_value("flush_all", 0, 32'(issue_count));
    check_value("flush_all", 0, 32'(issue_valid));
endtask

//--- tb/rs_tb.sv
// testbench top: clock, reset, DUT instance, lcg, value check, test sequence
`default_nettype none

module rs_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RS     = 16;
    localparam int SEED       = 90890;
    localparam int TIMEOUT    = 100;
    localparam int CLK_PERIOD = 10;
    localparam int IDX_W      = $clog2(NUM_RS);

    ////////////////////
    // DUT signals
    ////////////////////

    logic clk = 1'b0;
    logic rst;
    logic dispatch_en;
    logic issue_en;
    logic ex_stall;
    logic complete_en;
    logic flush;
    rs_pkg::lane_mask_t id_valid, src1_used, src2_used, mt_ready1, mt_ready2, release_valid;
    rs_pkg::op_t [rs_pkg::LANES-1:0]      id_op;
    rs_pkg::word_t [rs_pkg::LANES-1:0]    rs1_value, rs2_value, rob_value1, rob_value2;
    rs_pkg::word_t [rs_pkg::LANES-1:0]    cdb_value;
    rs_pkg::rob_tag_t [rs_pkg::LANES-1:0] mt_tag1, mt_tag2, dest_tag, cdb_tag;
    logic [rs_pkg::LANES-1:0][IDX_W-1:0]  release_idx;
    // outputs
    logic [$clog2(NUM_RS+1)-1:0]          free_count;
    rs_pkg::lane_count_t                  issue_count;
    rs_pkg::lane_mask_t                   issue_valid;
    logic [rs_pkg::LANES-1:0][IDX_W-1:0]  issue_idx;
    rs_pkg::op_t [rs_pkg::LANES-1:0]      issue_op;
    rs_pkg::word_t [rs_pkg::LANES-1:0]    issue_v1, issue_v2;
    rs_pkg::rob_tag_t [rs_pkg::LANES-1:0] issue_dest;

    logic [31:0] lcg_state;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rs_top #(.NUM_RS(NUM_RS)) dut_i (.*);

    ////////////////////
    // helpers
    ////////////////////

    // lcg step, full 32-bit state
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s] expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // drive point, 1 ns past the rising edge, all inputs idle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        clear_inputs();
    endtask

    // outputs settled well before the next edge
    task automatic sample_point();
        @(negedge clk);
    endtask

    task automatic clear_inputs();
        dispatch_en   = 1'b0;
        issue_en      = 1'b0;
        ex_stall      = 1'b0;
        complete_en   = 1'b0;
        flush         = 1'b0;
        id_valid      = '0;
        src1_used     = '0;
        src2_used     = '0;
        mt_ready1     = '0;
        mt_ready2     = '0;
        release_valid = '0;
        release_idx   = '0;
        id_op         = '0;
        rs1_value     = '0;
        rs2_value     = '0;
        rob_value1    = '0;
        rob_value2    = '0;
        cdb_value     = '0;
        mt_tag1       = '0;
        mt_tag2       = '0;
        dest_tag      = '0;
        cdb_tag       = '0;
    endtask

    // one flush cycle, table empty afterwards
    task automatic clear_table();
        next_cycle();
        flush = 1'b1;
        sample_point();
    endtask

    `include "rs_tb_tests.svh"

    ////////////////////
    // sequence
    ////////////////////

    initial begin
        lcg_state = SEED;
        rst       = 1'b1;
        clear_inputs();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        sample_point();
        reset_state();
        ready_dispatch_issue();
        tag_wait_wakeup();
        stall_and_release();
        full_table();
        flush_all();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/rs_top.sv
// reservation station top: free and ready counts, dispatch and issue sizing, issue mux
`default_nettype none

module rs_top #(
    parameter int NUM_RS = 16
) (
    input  logic                                        clk,
    input  logic                                        rst,
    // dispatch
    input  logic                                        dispatch_en,
    input  rs_pkg::lane_mask_t                          id_valid,
    input  rs_pkg::op_t [rs_pkg::LANES-1:0]             id_op,
    input  rs_pkg::lane_mask_t                          src1_used,
    input  rs_pkg::lane_mask_t                          src2_used,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]           rs1_value,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]           rs2_value,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]        mt_tag1,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]        mt_tag2,
    input  rs_pkg::lane_mask_t                          mt_ready1,
    input  rs_pkg::lane_mask_t                          mt_ready2,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]           rob_value1,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]           rob_value2,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]        dest_tag,
    // issue and execute
    input  logic                                        issue_en,
    input  logic                                        ex_stall,
    input  rs_pkg::lane_mask_t                          release_valid,
    input  logic [rs_pkg::LANES-1:0][$clog2(NUM_RS)-1:0] release_idx,
    // complete
    input  logic                                        complete_en,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]        cdb_tag,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]           cdb_value,
    input  logic                                        flush,
    // outputs
    output logic [$clog2(NUM_RS+1)-1:0]                 free_count,
    output rs_pkg::lane_count_t                         issue_count,
    output rs_pkg::lane_mask_t                          issue_valid,
    output logic [rs_pkg::LANES-1:0][$clog2(NUM_RS)-1:0] issue_idx,
    output rs_pkg::op_t [rs_pkg::LANES-1:0]             issue_op,
    output rs_pkg::word_t [rs_pkg::LANES-1:0]           issue_v1,
    output rs_pkg::word_t [rs_pkg::LANES-1:0]           issue_v2,
    output rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]        issue_dest
);

    localparam int IDX_W = $clog2(NUM_RS);
    localparam int CNT_W = $clog2(NUM_RS + 1);

    logic [NUM_RS-1:0]                  busy_mask;
    logic [NUM_RS-1:0]                  ready_mask;
    rs_pkg::op_t [NUM_RS-1:0]           ent_op;
    rs_pkg::rob_tag_t [NUM_RS-1:0]      ent_dest;
    rs_pkg::word_t [NUM_RS-1:0]         ent_v1;
    rs_pkg::word_t [NUM_RS-1:0]         ent_v2;

    rs_pkg::lane_mask_t                 free_found;
    rs_pkg::lane_mask_t                 ready_found;
    logic [rs_pkg::LANES-1:0][IDX_W-1:0] free_idx;
    logic [rs_pkg::LANES-1:0][IDX_W-1:0] ready_idx;

    rs_pkg::rob_tag_t [rs_pkg::LANES-1:0] cap_t1;
    rs_pkg::rob_tag_t [rs_pkg::LANES-1:0] cap_t2;
    rs_pkg::word_t [rs_pkg::LANES-1:0]    cap_v1;
    rs_pkg::word_t [rs_pkg::LANES-1:0]    cap_v2;

    logic [CNT_W-1:0]                   ready_count;
    rs_pkg::lane_count_t                lead_run;
    rs_pkg::lane_count_t                disp_count;
    rs_pkg::lane_mask_t                 wr_mask;
    rs_pkg::lane_mask_t                 mark_mask;

    // count n -> lanes 0..n-1 set
    function automatic rs_pkg::lane_mask_t count_to_mask(input rs_pkg::lane_count_t n);
        rs_pkg::lane_mask_t m;
        for (int k = 0; k < rs_pkg::LANES; k++) begin
            m[k] = (k < int'(n));
        end
        return m;
    endfunction

    ////////////////////
    // counting
    ////////////////////

    always_comb begin
        free_count  = '0;
        ready_count = '0;
        for (int e = 0; e < NUM_RS; e++) begin
            free_count  = free_count + CNT_W'(!busy_mask[e]);
            ready_count = ready_count + CNT_W'(ready_mask[e]);
        end
    end

    // leading valid run from lane 0, a gap ends it
    always_comb begin
        if (!dispatch_en || !id_valid[0]) begin
            lead_run = 2'd0;
        end else if (!id_valid[1]) begin
            lead_run = 2'd1;
        end else if (!id_valid[2]) begin
            lead_run = 2'd2;
        end else begin
            lead_run = 2'd3;
        end
    end

    // min(run, free) and min(3, ready)
    assign disp_count  = (free_count < CNT_W'(lead_run)) ? rs_pkg::lane_count_t'(free_count)
                                                         : lead_run;
    assign issue_count = !issue_en ? 2'd0 :
                         (ready_count < CNT_W'(rs_pkg::LANES)) ?
                         rs_pkg::lane_count_t'(ready_count) :
                         rs_pkg::lane_count_t'(rs_pkg::LANES);

    assign wr_mask     = count_to_mask(disp_count) & free_found;
    assign issue_valid = count_to_mask(issue_count) & ready_found;
    // stall holds the entries for another look next cycle
    assign mark_mask   = ex_stall ? '0 : issue_valid;

    ////////////////////
    // selectors
    ////////////////////

    rs_grant_select #(.NUM_RS(NUM_RS)) u_free_sel (
        .req   (~busy_mask),
        .found (free_found),
        .idx   (free_idx)
    );

    rs_grant_select #(.NUM_RS(NUM_RS)) u_ready_sel (
        .req   (ready_mask),
        .found (ready_found),
        .idx   (ready_idx)
    );

    rs_operand_capture u_capture (
        .src1_used   (src1_used),
        .src2_used   (src2_used),
        .mt_tag1     (mt_tag1),
        .mt_tag2     (mt_tag2),
        .mt_ready1   (mt_ready1),
        .mt_ready2   (mt_ready2),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .rob_value1  (rob_value1),
        .rob_value2  (rob_value2),
        .complete_en (complete_en),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .t1          (cap_t1),
        .t2          (cap_t2),
        .v1          (cap_v1),
        .v2          (cap_v2)
    );

    rs_entry_table #(.NUM_RS(NUM_RS)) u_table (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .wr_mask       (wr_mask),
        .wr_idx        (free_idx),
        .wr_op         (id_op),
        .wr_dest       (dest_tag),
        .wr_t1         (cap_t1),
        .wr_t2         (cap_t2),
        .wr_v1         (cap_v1),
        .wr_v2         (cap_v2),
        .mark_mask     (mark_mask),
        .mark_idx      (ready_idx),
        .release_valid (release_valid),
        .release_idx   (release_idx),
        .complete_en   (complete_en),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .busy_mask     (busy_mask),
        .ready_mask    (ready_mask),
        .ent_op        (ent_op),
        .ent_dest      (ent_dest),
        .ent_v1        (ent_v1),
        .ent_v2        (ent_v2)
    );

    ////////////////////
    // issue mux
    ////////////////////

    // idle lanes carry zeros
    always_comb begin
        for (int k = 0; k < rs_pkg::LANES; k++) begin
            issue_idx[k]  = '0;
            issue_op[k]   = '0;
            issue_v1[k]   = '0;
            issue_v2[k]   = '0;
            issue_dest[k] = '0;
            if (issue_valid[k]) begin
                issue_idx[k]  = ready_idx[k];
                issue_op[k]   = ent_op[ready_idx[k]];
                issue_v1[k]   = ent_v1[ready_idx[k]];
                issue_v2[k]   = ent_v2[ready_idx[k]];
                issue_dest[k] = ent_dest[ready_idx[k]];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rs_entry_table.sv
// entry storage: dispatch write, cdb wakeup, issue mark, release, flush, checks
`default_nettype none

module rs_entry_table #(
    parameter int NUM_RS = 16
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        flush,
    // dispatch write
    input  rs_pkg::lane_mask_t                          wr_mask,
    input  logic [rs_pkg::LANES-1:0][$clog2(NUM_RS)-1:0] wr_idx,
    input  rs_pkg::op_t [rs_pkg::LANES-1:0]             wr_op,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]        wr_dest,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]        wr_t1,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]        wr_t2,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]           wr_v1,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]           wr_v2,
    // issue mark
    input  rs_pkg::lane_mask_t                          mark_mask,
    input  logic [rs_pkg::LANES-1:0][$clog2(NUM_RS)-1:0] mark_idx,
    // release from execute
    input  rs_pkg::lane_mask_t                          release_valid,
    input  logic [rs_pkg::LANES-1:0][$clog2(NUM_RS)-1:0] release_idx,
    // cdb
    input  logic                                        complete_en,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]        cdb_tag,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]           cdb_value,
    // state seen by the top
    output logic [NUM_RS-1:0]                           busy_mask,
    output logic [NUM_RS-1:0]                           ready_mask,
    output rs_pkg::op_t [NUM_RS-1:0]                    ent_op,
    output rs_pkg::rob_tag_t [NUM_RS-1:0]               ent_dest,
    output rs_pkg::word_t [NUM_RS-1:0]                  ent_v1,
    output rs_pkg::word_t [NUM_RS-1:0]                  ent_v2
);

    // control fields
    logic [NUM_RS-1:0]                busy;
    logic [NUM_RS-1:0]                issued;
    rs_pkg::rob_tag_t [NUM_RS-1:0]    t1;
    rs_pkg::rob_tag_t [NUM_RS-1:0]    t2;

    assign busy_mask = busy;

    // busy, both operands present, not yet handed to execute
    always_comb begin
        for (int e = 0; e < NUM_RS; e++) begin
            ready_mask[e] = busy[e] && t1[e] == '0 && t2[e] == '0 && !issued[e];
        end
    end

    ////////////////////
    // control state
    ////////////////////

    // later statements win: mark, release, wakeup, dispatch
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy   <= '0;
            issued <= '0;
            t1     <= '0;
            t2     <= '0;
        end else begin
            for (int k = 0; k < rs_pkg::LANES; k++) begin
                if (mark_mask[k]) begin
                    issued[mark_idx[k]] <= 1'b1;
                end
            end
            for (int k = 0; k < rs_pkg::LANES; k++) begin
                if (release_valid[k]) begin
                    busy[release_idx[k]]   <= 1'b0;
                    issued[release_idx[k]] <= 1'b0;
                    t1[release_idx[k]]     <= '0;
                    t2[release_idx[k]]     <= '0;
                end
            end
            // wakeup, tag 0 never matches
            if (complete_en) begin
                for (int k = 0; k < rs_pkg::LANES; k++) begin
                    for (int e = 0; e < NUM_RS; e++) begin
                        if (busy[e] && t1[e] != '0 && t1[e] == cdb_tag[k]) begin
                            t1[e] <= '0;
                        end
                        if (busy[e] && t2[e] != '0 && t2[e] == cdb_tag[k]) begin
                            t2[e] <= '0;
                        end
                    end
                end
            end
            // new entry overrides a same-cycle release
            for (int k = 0; k < rs_pkg::LANES; k++) begin
                if (wr_mask[k]) begin
                    busy[wr_idx[k]]   <= 1'b1;
                    issued[wr_idx[k]] <= 1'b0;
                    t1[wr_idx[k]]     <= wr_t1[k];
                    t2[wr_idx[k]]     <= wr_t2[k];
                end
            end
        end
    end

    ////////////////////
    // payload
    ////////////////////

    always_ff @(posedge clk) begin
        if (complete_en) begin
            for (int k = 0; k < rs_pkg::LANES; k++) begin
                for (int e = 0; e < NUM_RS; e++) begin
                    // value lands together with the tag clear above
                    if (busy[e] && t1[e] != '0 && t1[e] == cdb_tag[k]) begin
                        ent_v1[e] <= cdb_value[k];
                    end
                    if (busy[e] && t2[e] != '0 && t2[e] == cdb_tag[k]) begin
                        ent_v2[e] <= cdb_value[k];
                    end
                end
            end
        end
        for (int k = 0; k < rs_pkg::LANES; k++) begin
            if (wr_mask[k]) begin
                ent_op[wr_idx[k]]   <= wr_op[k];
                ent_dest[wr_idx[k]] <= wr_dest[k];
                ent_v1[wr_idx[k]]   <= wr_v1[k];
                ent_v2[wr_idx[k]]   <= wr_v2[k];
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // slot picking and release ordering in the top must respect entry state
    for (genvar k = 0; k < rs_pkg::LANES; k++) begin : g_chk
        // dispatch only into free entries
        a_wr_free: assert property (@(posedge clk) disable iff (rst)
            wr_mask[k] |-> !busy[wr_idx[k]]);
        // issue mark only on an entry that was ready
        a_mark_ready: assert property (@(posedge clk) disable iff (rst)
            mark_mask[k] |-> ready_mask[mark_idx[k]]);
        // execute releases only entries it holds
        a_rel_busy: assert property (@(posedge clk) disable iff (rst)
            release_valid[k] |-> busy[release_idx[k]]);
    end

endmodule

`default_nettype wire

//--- rtl/rs_operand_capture.sv
// dispatch operand resolution against register file, map table, rob and cdb
`default_nettype none

module rs_operand_capture (
    input  rs_pkg::lane_mask_t                      src1_used,
    input  rs_pkg::lane_mask_t                      src2_used,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]    mt_tag1,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]    mt_tag2,
    input  rs_pkg::lane_mask_t                      mt_ready1,
    input  rs_pkg::lane_mask_t                      mt_ready2,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]       rs1_value,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]       rs2_value,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]       rob_value1,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]       rob_value2,
    input  logic                                    complete_en,
    input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]    cdb_tag,
    input  rs_pkg::word_t [rs_pkg::LANES-1:0]       cdb_value,
    output rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]    t1,
    output rs_pkg::rob_tag_t [rs_pkg::LANES-1:0]    t2,
    output rs_pkg::word_t [rs_pkg::LANES-1:0]       v1,
    output rs_pkg::word_t [rs_pkg::LANES-1:0]       v2
);

    // one source: regfile, then cdb, then rob, else wait on the tag
    function automatic void resolve(
        input  logic                                 used,
        input  rs_pkg::rob_tag_t                     map_tag,
        input  logic                                 map_ready,
        input  rs_pkg::word_t                        rf_val,
        input  rs_pkg::word_t                        rob_val,
        input  logic                                 cdb_en,
        input  rs_pkg::rob_tag_t [rs_pkg::LANES-1:0] bus_tag,
        input  rs_pkg::word_t [rs_pkg::LANES-1:0]    bus_val,
        output rs_pkg::rob_tag_t                     tag,
        output rs_pkg::word_t                        val
    );
        logic          hit;
        rs_pkg::word_t hit_val;
        hit     = 1'b0;
        hit_val = '0;
        // ascending scan, highest matching lane ends up winning
        for (int j = 0; j < rs_pkg::LANES; j++) begin
            if (cdb_en && bus_tag[j] == map_tag) begin
                hit     = 1'b1;
                hit_val = bus_val[j];
            end
        end
        if (!used || map_tag == '0) begin
            // architectural value, nothing in flight
            tag = '0;
            val = rf_val;
        end else if (hit) begin
            // producer completes this very cycle
            tag = '0;
            val = hit_val;
        end else if (map_ready) begin
            tag = '0;
            val = rob_val;
        end else begin
            // still pending, value filled by wakeup later
            tag = map_tag;
            val = '0;
        end
    endfunction

    ////////////////////
    // six sources
    ////////////////////

    always_comb begin
        for (int k = 0; k < rs_pkg::LANES; k++) begin
            resolve(src1_used[k], mt_tag1[k], mt_ready1[k], rs1_value[k], rob_value1[k],
                    complete_en, cdb_tag, cdb_value, t1[k], v1[k]);
            resolve(src2_used[k], mt_tag2[k], mt_ready2[k], rs2_value[k], rob_value2[k],
                    complete_en, cdb_tag, cdb_value, t2[k], v2[k]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/rs_grant_select.sv
// lowest-first multi-grant selector, per-lane found flags and entry indexes
`default_nettype none

module rs_grant_select #(
    parameter int NUM_RS = 16
) (
    input  logic [NUM_RS-1:0]                           req,
    output rs_pkg::lane_mask_t                          found,
    output logic [rs_pkg::LANES-1:0][$clog2(NUM_RS)-1:0] idx
);

    localparam int IDX_W = $clog2(NUM_RS);

    // requests still open after the lower lanes took theirs
    logic [NUM_RS-1:0] rem;

    always_comb begin
        rem   = req;
        found = '0;
        idx   = '0;
        for (int k = 0; k < rs_pkg::LANES; k++) begin
            // scan downward so the lowest set bit is the last one kept
            for (int i = NUM_RS - 1; i >= 0; i--) begin
                if (rem[i]) begin
                    found[k] = 1'b1;
                    idx[k]   = IDX_W'(i);
                end
            end
            // drop the lowest set bit for the next lane
            rem = rem & (rem - NUM_RS'(1));
        end
    end

endmodule

`default_nettype wire

//--- rtl/rs_pkg.sv
// shared lane count, tag and word widths, vector typedefs
`default_nettype none

package rs_pkg;

    ////////////////////
    // lanes
    ////////////////////

    // dispatch, issue, cdb and release all run this wide
    localparam int LANES = 3;

    ////////////////////
    // widths
    ////////////////////

    // rob tag, 0 reserved for no tag
    localparam int ROB_TAG_W = 5;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // operand value
    typedef logic [31:0] word_t;

    // opaque instruction payload, not decoded here
    typedef logic [31:0] op_t;

    // one bit per lane
    typedef logic [LANES-1:0] lane_mask_t;

    // 0 to 3 lanes
    typedef logic [1:0] lane_count_t;

endpackage

`default_nettype wire
